//--- logic/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////////////////////////
	// widths and cache geometry
	//////////////////////////////////////////////////
	localparam int xlen        = 32;  // address and data width
	localparam int ways        = 2;   // words handed to decode per cycle
	localparam int line_bits   = 64;  // one cache line holds two words
	localparam int icache_sets = 16;  // direct mapped, one line per set
	localparam int index_bits  = 4;   // log2 of icache_sets
	localparam int tag_bits    = xlen - 3 - index_bits;  // above index and byte offset

	localparam logic [6:0] opcode_jal = 7'b1101111;  // jump and link

	//////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////

	// one slot of the fetch packet going to decode
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] inst;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;  // pc + 4
	} if_id_packet_t;

	// plain view of a word, only the opcode is split out
	typedef struct packed {
		logic [24:0] fields;
		logic [6:0]  opcode;
	} inst_raw_t;

	// J type layout, immediate bits are scattered
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_jal_t;

	typedef union packed {
		inst_raw_t raw;
		inst_jal_t jal;
	} inst_word_u;

	// predictor result
	typedef struct packed {
		logic            taken;   // a jal was found
		logic            way;     // slot holding that jal
		logic [xlen-1:0] target;  // next fetch pc
	} pred_t;

	// wishbone classic master side
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [xlen-1:0] adr;
	} wb_req_t;

	// wishbone classic slave side
	typedef struct packed {
		logic [xlen-1:0] dat;
		logic            ack;
	} wb_rsp_t;

	// line write from fill controller into the cache
	typedef struct packed {
		logic                 we;
		logic [index_bits-1:0] index;
		logic [tag_bits-1:0]   tag;
		logic [line_bits-1:0]  line;
	} fill_t;

endpackage

//--- logic/if_stage.sv
`timescale 1ns/1ps

module if_stage (
	input  logic                                                 clock,
	input  logic                                                 reset,
	input  logic                                                 stall,
	input  logic                                                 take_branch,
	input  logic [fetch_pkg::xlen-1:0]                           target_pc,
	input  logic [fetch_pkg::ways-1:0][fetch_pkg::line_bits-1:0] line,
	input  logic [fetch_pkg::ways-1:0]                           hit,
	input  fetch_pkg::pred_t                                     pred,
	output logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0]      fetch_addr,
	output fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0]       packets
);

	logic [fetch_pkg::xlen-1:0]                      pc_reg;    // pc of way 0
	logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0] way_pc;    // pc of each slot
	logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0] word_sel;  // word picked from line
	logic                                            all_hit;
	logic                                            pc_enable;

	// consecutive words, each slot 4 bytes past the one before
	always_comb begin
		way_pc[0] = pc_reg;
		for (int i = 1; i < fetch_pkg::ways; i++) begin
			way_pc[i] = way_pc[i-1] + 32'd4;
		end
	end

	assign all_hit = &hit;  // a packet only goes out when every slot hit

	//////////////////////////////////////////////////
	// per slot address, word select and validity
	//////////////////////////////////////////////////
	for (genvar i = 0; i < fetch_pkg::ways; i++) begin : g_way
		assign fetch_addr[i] = {way_pc[i][fetch_pkg::xlen-1:3], 3'b000};  // line aligned
		// pc bit 2 picks the upper word of the 64-bit line
		assign word_sel[i] = way_pc[i][2] ? line[i][63:32] : line[i][31:0];

		assign packets[i].inst = word_sel[i];
		assign packets[i].pc   = way_pc[i];
		assign packets[i].npc  = way_pc[i] + 32'd4;

		// slots behind a taken jal are killed
		assign packets[i].valid = all_hit
			&& (word_sel[i] != '0)  // zero word marks an empty slot
			&& !stall
			&& (!pred.taken || (i <= int'(pred.way)));
	end

	// advance only once the whole fetch group is present
	assign pc_enable = !stall && all_hit;

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;                // fetch starts at 0
		end else if (take_branch) begin
			pc_reg <= target_pc;         // redirect wins over stall and miss
		end else if (pc_enable) begin
			pc_reg <= pred.target;       // jal target or pc + 8
		end
	end

endmodule

//--- logic/next_pc_predict.sv
`timescale 1ns/1ps

module next_pc_predict (
	input  fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0] packets,
	output fetch_pkg::pred_t                               pred
);

	fetch_pkg::inst_word_u [fetch_pkg::ways-1:0]           word;     // decoded views
	logic [fetch_pkg::ways-1:0]                            is_jal;
	logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0]       jal_dest; // pc + imm per slot

	// rebuild the J immediate from its scattered fields, bit 0 is always zero
	function automatic logic [fetch_pkg::xlen-1:0] j_imm(input fetch_pkg::inst_word_u w);
		return {
			{11{w.jal.imm_20}},  // sign extension
			w.jal.imm_20,
			w.jal.imm_19_12,
			w.jal.imm_11,
			w.jal.imm_10_1,
			1'b0
		};
	endfunction

	//////////////////////////////////////////////////
	// predecode each slot
	//////////////////////////////////////////////////
	for (genvar i = 0; i < fetch_pkg::ways; i++) begin : g_pre
		assign word[i]     = packets[i].inst;
		assign is_jal[i]   = (word[i].raw.opcode == fetch_pkg::opcode_jal);
		assign jal_dest[i] = packets[i].pc + j_imm(word[i]);
	end

	// scan from the top down so the lowest jal slot wins
	always_comb begin
		pred.taken  = 1'b0;
		pred.way    = 1'b0;
		pred.target = packets[0].pc + 32'd8;  // sequential, next fetch group
		for (int i = fetch_pkg::ways - 1; i >= 0; i--) begin
			if (is_jal[i]) begin
				pred.taken  = 1'b1;
				pred.way    = i[0];
				pred.target = jal_dest[i];
			end
		end
	end

endmodule

//--- logic/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                                                 clock,
	input  logic                                                 reset,
	input  logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0]      fetch_addr,
	input  fetch_pkg::fill_t                                     fill,
	output logic [fetch_pkg::ways-1:0][fetch_pkg::line_bits-1:0] line,
	output logic [fetch_pkg::ways-1:0]                           hit,
	output logic                                                 miss_valid,
	output logic [fetch_pkg::xlen-1:0]                           miss_addr
);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////
	logic [fetch_pkg::tag_bits-1:0]  tag_mem  [fetch_pkg::icache_sets];
	logic [fetch_pkg::line_bits-1:0] data_mem [fetch_pkg::icache_sets];
	logic [fetch_pkg::icache_sets-1:0] valid_bits;  // one per set

	// per port address split
	logic [fetch_pkg::ways-1:0][fetch_pkg::index_bits-1:0] rd_index;
	logic [fetch_pkg::ways-1:0][fetch_pkg::tag_bits-1:0]   rd_tag;

	// valid bits are the only state that needs clearing
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (fill.we) begin
			valid_bits[fill.index] <= 1'b1;
		end
	end

	// tag and line written together on the fill pulse
	always_ff @(posedge clock) begin
		if (fill.we) begin
			tag_mem[fill.index]  <= fill.tag;
			data_mem[fill.index] <= fill.line;
		end
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////
	for (genvar i = 0; i < fetch_pkg::ways; i++) begin : g_port
		assign rd_index[i] = fetch_addr[i][3 +: fetch_pkg::index_bits];
		assign rd_tag[i]   = fetch_addr[i][fetch_pkg::xlen-1 -: fetch_pkg::tag_bits];

		// asynchronous read, a fill shows up the cycle after its write
		assign line[i] = data_mem[rd_index[i]];
		assign hit[i]  = valid_bits[rd_index[i]] && (tag_mem[rd_index[i]] == rd_tag[i]);
	end

	//////////////////////////////////////////////////
	// miss report
	//////////////////////////////////////////////////
	assign miss_valid = ~&hit;  // any port missing

	// lowest numbered missing way gets refilled first
	always_comb begin
		miss_addr = {fetch_addr[0][fetch_pkg::xlen-1:3], 3'b000};
		for (int i = fetch_pkg::ways - 1; i >= 0; i--) begin
			if (!hit[i]) begin
				miss_addr = {fetch_addr[i][fetch_pkg::xlen-1:3], 3'b000};
			end
		end
	end

endmodule

//--- logic/icache_fill_ctrl.sv
`timescale 1ns/1ps

module icache_fill_ctrl (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       miss_valid,
	input  logic [fetch_pkg::xlen-1:0] miss_addr,
	input  fetch_pkg::wb_rsp_t         wb_rsp,
	output fetch_pkg::wb_req_t         wb_req,
	output fetch_pkg::fill_t           fill
);

	typedef enum logic [1:0] {
		st_idle,   // waiting for a miss
		st_req,    // cyc and stb held until ack
		st_gap,    // bus idle between the two beats
		st_write   // one-cycle line write into the cache
	} state_t;

	state_t state;
	logic   beat;  // 0 low word, 1 high word

	// payload, loaded along the way
	logic [fetch_pkg::xlen-4:0]         line_addr;  // line number, byte offset dropped
	logic [1:0][fetch_pkg::xlen-1:0]    word_buf;   // [0] low word, [1] high word

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			beat  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (miss_valid) begin
						state <= st_req;
						beat  <= 1'b0;  // always start on the low word
					end
				end
				st_req: begin
					if (wb_rsp.ack) begin
						state <= beat ? st_write : st_gap;
						beat  <= ~beat;  // wraps back to 0 after the high word
					end
				end
				st_gap:   state <= st_req;
				st_write: state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	// latch the line address once, the cache request may move meanwhile
	always_ff @(posedge clock) begin
		if (state == st_idle && miss_valid) begin
			line_addr <= miss_addr[fetch_pkg::xlen-1:3];
		end
		if (state == st_req && wb_rsp.ack) begin
			word_buf[beat] <= wb_rsp.dat;  // capture on the ack cycle
		end
	end

	//////////////////////////////////////////////////
	// bus and fill outputs
	//////////////////////////////////////////////////
	always_comb begin
		wb_req.cyc = (state == st_req);
		wb_req.stb = (state == st_req);  // classic cycle, stb follows cyc
		wb_req.we  = 1'b0;               // reads only
		wb_req.adr = {line_addr, beat, 2'b00};
	end

	always_comb begin
		fill.we    = (state == st_write);
		fill.index = line_addr[fetch_pkg::index_bits-1:0];
		fill.tag   = line_addr[fetch_pkg::xlen-4 -: fetch_pkg::tag_bits];
		fill.line  = word_buf;  // high word in the upper half
	end

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic                                           stall,
	input  logic                                           take_branch,
	input  logic [fetch_pkg::xlen-1:0]                     target_pc,
	input  fetch_pkg::wb_rsp_t                             wb_rsp,
	output fetch_pkg::wb_req_t                             wb_req,
	output fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0] packets
);

	//////////////////////////////////////////////////
	// internal wires
	//////////////////////////////////////////////////
	logic [fetch_pkg::ways-1:0][fetch_pkg::xlen-1:0]      fetch_addr;  // line aligned, per way
	logic [fetch_pkg::ways-1:0][fetch_pkg::line_bits-1:0] line;
	logic [fetch_pkg::ways-1:0]                           hit;
	logic                                                 miss_valid;
	logic [fetch_pkg::xlen-1:0]                           miss_addr;
	fetch_pkg::fill_t                                     fill;
	fetch_pkg::pred_t                                     pred;

	// pc, word select, validity
	if_stage if_stage_i (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.take_branch (take_branch),
		.target_pc   (target_pc),
		.line        (line),
		.hit         (hit),
		.pred        (pred),
		.fetch_addr  (fetch_addr),
		.packets     (packets)
	);

	// reads inst and pc only, the kill uses its result
	next_pc_predict next_pc_predict_i (
		.packets (packets),
		.pred    (pred)
	);

	icache icache_i (
		.clock      (clock),
		.reset      (reset),
		.fetch_addr (fetch_addr),
		.fill       (fill),
		.line       (line),
		.hit        (hit),
		.miss_valid (miss_valid),
		.miss_addr  (miss_addr)
	);

	// refill over wishbone, two beats per line
	icache_fill_ctrl icache_fill_ctrl_i (
		.clock      (clock),
		.reset      (reset),
		.miss_valid (miss_valid),
		.miss_addr  (miss_addr),
		.wb_rsp     (wb_rsp),
		.wb_req     (wb_req),
		.fill       (fill)
	);

endmodule

//--- verif/fetch_tb_mem.sv
`timescale 1ns/1ps

module fetch_tb_mem (
	input  logic               clock,
	input  logic               reset,
	input  fetch_pkg::wb_req_t wb_req,
	output fetch_pkg::wb_rsp_t wb_rsp
);

	//////////////////////////////////////////////////
	// program image, 256 words from address 0
	//////////////////////////////////////////////////
	logic [31:0] image [256];  // loaded by the testbench before reset ends

	logic [1:0] wait_left;  // cycles still to wait before ack
	logic       busy;       // a request is being delayed

	// wishbone classic slave with a registered ack
	// one process so the seed covers every delay drawn below
	initial begin
		void'($urandom(32'hdee1));  // seed once for the whole run
		wb_rsp <= '0;
		busy = 1'b0;
		wait_left = 2'd0;
		forever begin
			@(posedge clock);
			if (reset) begin
				wb_rsp.ack <= 1'b0;
				busy = 1'b0;
			end else if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
				// new request, draw its delay of 0 to 3 cycles
				if (!busy) begin
					busy = 1'b1;
					wait_left = 2'($urandom_range(3, 0));
				end
				if (wait_left == 2'd0) begin
					wb_rsp.ack <= 1'b1;
					wb_rsp.dat <= image[wb_req.adr[9:2]];  // word address, wraps at 1 KB
					busy = 1'b0;
				end else begin
					wait_left = wait_left - 2'd1;
				end
			end else begin
				wb_rsp.ack <= 1'b0;  // ack lasts a single cycle
			end
		end
	end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	logic                                           clock;
	logic                                           reset;
	logic                                           stall;
	logic                                           take_branch;
	logic [fetch_pkg::xlen-1:0]                     target_pc;
	fetch_pkg::wb_req_t                             wb_req;
	fetch_pkg::wb_rsp_t                             wb_rsp;
	fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0] packets;

	logic [31:0] exp_pc;            // pc the next valid group starts at
	int          valid_count = 0;   // cycles with any valid slot

	// bus monitor history
	logic        prev_stb;
	logic        prev_ack;
	logic [31:0] prev_adr;
	logic [31:0] line_adr;          // address of the first beat
	logic        second_beat;

	fetch_top fetch_top_i (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.take_branch (take_branch),
		.target_pc   (target_pc),
		.wb_rsp      (wb_rsp),
		.wb_req      (wb_req),
		.packets     (packets)
	);

	fetch_tb_mem fetch_tb_mem_i (
		.clock  (clock),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;  // 100 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %s got %h expected %h", name, got, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// J type encoding with imm[20|10:1|11|19:12] above rd
	function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [31:0] offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'h6f};
	endfunction

	// 0x40 jumps to 0x80 and 0x8c to 0xc4 and 0x100 back to 0
	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			fetch_tb_mem_i.image[i] = {25'(i), 7'h13};  // addi style word tagged by its index
		end
		fetch_tb_mem_i.image['h40 >> 2]  = encode_jal(5'd1, 32'h40);    // way 0 jal
		fetch_tb_mem_i.image['h8c >> 2]  = encode_jal(5'd1, 32'h38);    // way 1 jal to an odd word
		fetch_tb_mem_i.image['hd0 >> 2]  = 32'd0;                       // empty way 1
		fetch_tb_mem_i.image['hdc >> 2]  = 32'd0;                       // empty way 0
		fetch_tb_mem_i.image['h100 >> 2] = encode_jal(5'd0, -32'd256);  // backward jal in way 1
	endtask

	// expected group for a fetch at pc and the pc that follows it
	function automatic void expected_group(input logic [31:0] pc,
		output fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0] exp_pkt,
		output logic [31:0] next_pc);
		logic [31:0] slot_pc;
		logic [31:0] word;
		logic [31:0] imm;
		logic        found;
		found = 1'b0;
		next_pc = pc + 32'd8;  // sequential group
		for (int i = 0; i < fetch_pkg::ways; i++) begin
			slot_pc = pc + 32'(4 * i);
			word = fetch_tb_mem_i.image[slot_pc[9:2]];
			exp_pkt[i].pc = slot_pc;
			exp_pkt[i].npc = slot_pc + 32'd4;
			exp_pkt[i].inst = word;
			exp_pkt[i].valid = (word != 32'd0) && !found;  // nothing after the first jal
			if (!found && word[6:0] == 7'h6f) begin
				found = 1'b1;
				imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
				next_pc = slot_pc + imm;
			end
		end
	endfunction

	task automatic wait_valid_groups(input int n);
		int start;
		int cycles;
		start = valid_count;
		cycles = 0;
		while (valid_count - start < n) begin
			@(posedge clock);
			cycles++;
			if (cycles > n * 40) begin
				report_failure("timed out waiting for valid fetch packets");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// compare process sampled mid cycle
	//////////////////////////////////////////////////
	always @(negedge clock) begin
		fetch_pkg::if_id_packet_t [fetch_pkg::ways-1:0] exp_pkt;
		logic [31:0] next_pc;
		logic        any_valid;
		any_valid = 1'b0;
		for (int i = 0; i < fetch_pkg::ways; i++) begin
			any_valid = any_valid | packets[i].valid;
		end
		if (reset) begin
			exp_pc = 32'd0;
		end else begin
			if (stall && any_valid) begin
				report_failure("a packet was valid while stall was high");
			end
			if (any_valid) begin
				expected_group(exp_pc, exp_pkt, next_pc);
				for (int i = 0; i < fetch_pkg::ways; i++) begin
					check_value($sformatf("packets[%0d].valid", i), 32'(packets[i].valid),
						32'(exp_pkt[i].valid));
					check_value($sformatf("packets[%0d].pc", i), packets[i].pc, exp_pkt[i].pc);
					check_value($sformatf("packets[%0d].npc", i), packets[i].npc, exp_pkt[i].npc);
					check_value($sformatf("packets[%0d].inst", i), packets[i].inst,
						exp_pkt[i].inst);
				end
				valid_count++;
				exp_pc = next_pc;
			end
			if (take_branch) exp_pc = target_pc;  // lands at the coming edge
		end
	end

	// wishbone classic rules and line pairing of the two beats
	always @(negedge clock) begin
		if (reset) begin
			prev_stb = 1'b0;
			prev_ack = 1'b0;
			second_beat = 1'b0;
		end else begin
			check_value("wb_req.stb", 32'(wb_req.stb), 32'(wb_req.cyc));
			if (wb_req.cyc) check_value("wb_req.we", 32'(wb_req.we), 32'd0);  // reads only
			if (prev_stb && !prev_ack) begin
				check_value("wb_req.stb", 32'(wb_req.stb), 32'd1);  // held until ack
				check_value("wb_req.adr", wb_req.adr, prev_adr);
			end
			if (prev_ack) check_value("wb_req.stb", 32'(wb_req.stb), 32'd0);  // gap after ack
			if (wb_req.stb && wb_rsp.ack) begin
				if (!second_beat) begin
					check_value("wb_req.adr[2:0]", 32'(wb_req.adr[2:0]), 32'd0);
					line_adr = wb_req.adr;
				end else begin
					check_value("wb_req.adr", wb_req.adr, line_adr + 32'd4);  // high word
				end
				second_beat = !second_beat;
			end
			prev_stb = wb_req.stb;
			prev_ack = wb_rsp.ack;
			prev_adr = wb_req.adr;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin
		reset       <= 1'b1;
		stall       <= 1'b0;
		take_branch <= 1'b0;
		target_pc   <= 32'd0;
		load_program();
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		wait_valid_groups(45);  // more than two passes of the loop

		// freeze and then resume at the same pc
		stall <= 1'b1;
		repeat (12) @(posedge clock);
		stall <= 1'b0;
		wait_valid_groups(6);

		// redirect while stalled
		stall <= 1'b1;
		repeat (3) @(posedge clock);
		take_branch <= 1'b1;
		target_pc   <= 32'h24;  // odd word so the group spans two lines
		@(posedge clock);
		take_branch <= 1'b0;
		repeat (3) @(posedge clock);
		stall <= 1'b0;
		wait_valid_groups(30);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- tb.f
logic/fetch_pkg.sv
logic/if_stage.sv
logic/next_pc_predict.sv
logic/icache.sv
logic/icache_fill_ctrl.sv
logic/fetch_top.sv
verif/fetch_tb_mem.sv
verif/fetch_tb.sv
